//--- id_stage.f
logic/id_pkg.sv
logic/id_ifs.sv
logic/inst_decoder.sv
logic/operand_fwd.sv
logic/branch_unit.sv
logic/id_ex_reg.sv
logic/id_stage.sv
tests/id_stage_props.sv
tests/id_stage_tb.sv

//--- logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
	input id_pkg::word_t pc_i,
	input id_pkg::inst_t inst_i,
	input id_pkg::br_kind_e br_kind_i,
	input logic link_i,
	operand_if.br opnd,
	output logic branch_flag_o,
	output id_pkg::word_t branch_target_o,
	output id_pkg::word_t link_addr_o
);

	id_pkg::word_t pc_plus_4;
	id_pkg::word_t offset;
	logic taken;

	assign pc_plus_4 = pc_i + 32'd4;
	assign offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

	always_comb begin
		case (br_kind_i)
			id_pkg::BR_J, id_pkg::BR_JR: taken = 1'b1;
			id_pkg::BR_EQ: taken = (opnd.reg1 == opnd.reg2);
			id_pkg::BR_NE: taken = (opnd.reg1 != opnd.reg2);
			id_pkg::BR_LEZ: taken = opnd.reg1[31] || (opnd.reg1 == '0);
			id_pkg::BR_GTZ: taken = !opnd.reg1[31] && (opnd.reg1 != '0);
			id_pkg::BR_LTZ: taken = opnd.reg1[31];
			id_pkg::BR_GEZ: taken = !opnd.reg1[31];
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (br_kind_i)
			id_pkg::BR_NONE: branch_target_o = '0;
			id_pkg::BR_J: branch_target_o = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
			id_pkg::BR_JR: branch_target_o = opnd.reg1;
			default: branch_target_o = pc_plus_4 + offset;   // relative to delay slot
		endcase
	end

	// operands are stale during a load-use stall
	assign branch_flag_o = taken & ~opnd.stall;
	assign link_addr_o = link_i ? pc_i + 32'd8 : '0;

endmodule

//--- logic/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
	input logic clk,
	input logic rst_n_i,
	input logic stall_i,
	input logic branch_flag_i,
	input id_pkg::word_t link_addr_i,
	input id_pkg::inst_t inst_i,
	id_ctrl_if.pipe ctrl,
	input id_pkg::word_t reg1_i,
	input id_pkg::word_t reg2_i,
	output id_pkg::alusel_t ex_alusel_o,
	output id_pkg::aluop_t ex_aluop_o,
	output id_pkg::word_t ex_reg1_o,
	output id_pkg::word_t ex_reg2_o,
	output id_pkg::reg_addr_t ex_waddr_o,
	output logic ex_we_o,
	output id_pkg::word_t ex_link_addr_o,
	output id_pkg::inst_t ex_inst_o,
	output logic ex_in_delayslot_o
);

	logic ds_pending;   // next real instruction is a delay slot

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_alusel_o <= id_pkg::ALUSEL_NOP;
			ex_aluop_o <= id_pkg::ALUOP_NOP;
			ex_reg1_o <= '0;
			ex_reg2_o <= '0;
			ex_waddr_o <= '0;
			ex_we_o <= 1'b0;
			ex_link_addr_o <= '0;
			ex_inst_o <= '0;
			ex_in_delayslot_o <= 1'b0;
			ds_pending <= 1'b0;
		end else begin
			// a stall sends a bubble down and leaves ds_pending alone
			ex_alusel_o <= stall_i ? id_pkg::ALUSEL_NOP : ctrl.alusel;
			ex_aluop_o <= stall_i ? id_pkg::ALUOP_NOP : ctrl.aluop;
			ex_reg1_o <= stall_i ? '0 : reg1_i;
			ex_reg2_o <= stall_i ? '0 : reg2_i;
			ex_waddr_o <= stall_i ? '0 : ctrl.waddr;
			ex_we_o <= ctrl.we & ~stall_i;
			ex_link_addr_o <= stall_i ? '0 : link_addr_i;
			ex_inst_o <= stall_i ? '0 : inst_i;
			ex_in_delayslot_o <= ds_pending & ~stall_i;
			ds_pending <= stall_i ? ds_pending : branch_flag_i;
		end
	end

endmodule

//--- logic/id_ifs.sv
`timescale 1ns/1ps

// source operand requests and the forwarded values
interface operand_if;
	logic reg1_re;
	logic reg2_re;
	id_pkg::reg_addr_t reg1_addr;
	id_pkg::reg_addr_t reg2_addr;
	id_pkg::word_t imm;
	id_pkg::word_t reg1;
	id_pkg::word_t reg2;
	logic stall;

	modport dec (output reg1_re, reg2_re, reg1_addr, reg2_addr, imm);
	modport fwd (
		input reg1_re, reg2_re, reg1_addr, reg2_addr, imm,
		output reg1, reg2, stall
	);
	modport br (input reg1, reg2, stall);
endinterface

// decoded control headed for EX
interface id_ctrl_if;
	id_pkg::alusel_t alusel;
	id_pkg::aluop_t aluop;
	logic we;
	id_pkg::reg_addr_t waddr;

	modport dec (output alusel, aluop, we, waddr);
	modport pipe (input alusel, aluop, we, waddr);
endinterface

//--- logic/id_pkg.sv
package id_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [7:0] aluop_t;
	typedef logic [2:0] alusel_t;

	typedef enum logic [3:0] {
		BR_NONE, BR_J, BR_JR, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
	} br_kind_e;

	localparam reg_addr_t RA_ADDR = 5'd31;   // link register

	// result class seen by EX
	localparam alusel_t ALUSEL_NOP         = 3'b000;
	localparam alusel_t ALUSEL_LOGIC       = 3'b001;
	localparam alusel_t ALUSEL_SHIFT       = 3'b010;
	localparam alusel_t ALUSEL_MATH        = 3'b100;
	localparam alusel_t ALUSEL_JUMP_BRANCH = 3'b110;
	localparam alusel_t ALUSEL_LOAD_STORE  = 3'b111;

	localparam aluop_t ALUOP_NOP    = 8'b0000_0000;
	localparam aluop_t ALUOP_AND    = 8'b0010_0100;
	localparam aluop_t ALUOP_OR     = 8'b0010_0101;
	localparam aluop_t ALUOP_XOR    = 8'b0010_0110;
	localparam aluop_t ALUOP_NOR    = 8'b0010_0111;
	localparam aluop_t ALUOP_SLL    = 8'b0111_1100;
	localparam aluop_t ALUOP_SRL    = 8'b0000_0010;
	localparam aluop_t ALUOP_SRA    = 8'b0000_0011;
	localparam aluop_t ALUOP_ADD    = 8'b0010_0000;
	localparam aluop_t ALUOP_ADDU   = 8'b0010_0001;
	localparam aluop_t ALUOP_SUB    = 8'b0010_0010;
	localparam aluop_t ALUOP_SUBU   = 8'b0010_0011;
	localparam aluop_t ALUOP_SLT    = 8'b0010_1010;
	localparam aluop_t ALUOP_SLTU   = 8'b0010_1011;
	localparam aluop_t ALUOP_J      = 8'b0100_1111;
	localparam aluop_t ALUOP_JAL    = 8'b0101_0000;
	localparam aluop_t ALUOP_JR     = 8'b0000_1000;
	localparam aluop_t ALUOP_JALR   = 8'b0000_1001;
	localparam aluop_t ALUOP_BEQ    = 8'b0101_0001;
	localparam aluop_t ALUOP_BNE    = 8'b0101_0010;
	localparam aluop_t ALUOP_BLEZ   = 8'b0101_0011;
	localparam aluop_t ALUOP_BGTZ   = 8'b0101_0100;
	localparam aluop_t ALUOP_BLTZ   = 8'b0100_0000;
	localparam aluop_t ALUOP_BGEZ   = 8'b0100_0001;
	localparam aluop_t ALUOP_BLTZAL = 8'b0100_1010;
	localparam aluop_t ALUOP_BGEZAL = 8'b0100_1011;
	localparam aluop_t ALUOP_LW     = 8'b1110_0011;
	localparam aluop_t ALUOP_SW     = 8'b1110_1011;

	// primary opcodes, inst[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_SW      = 6'b101011;

	// SPECIAL function field, inst[5:0]
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// REGIMM rt field
	localparam logic [4:0] RT_BLTZ   = 5'b00000;
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

endpackage

//--- logic/id_stage.sv
`timescale 1ns/1ps

module id_stage (
	input logic clk,
	input logic rst_n_i,
	input id_pkg::word_t pc_i,
	input id_pkg::inst_t inst_i,
	input id_pkg::word_t reg1_data_i,
	input id_pkg::word_t reg2_data_i,
	input id_pkg::reg_addr_t ex_waddr_i,
	input logic ex_we_i,
	input id_pkg::word_t ex_wdata_i,
	input id_pkg::aluop_t ex_aluop_i,
	input id_pkg::reg_addr_t mem_waddr_i,
	input logic mem_we_i,
	input id_pkg::word_t mem_wdata_i,
	output logic reg1_re_o,
	output logic reg2_re_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	output logic branch_flag_o,
	output id_pkg::word_t branch_target_o,
	output logic stall_o,
	output id_pkg::alusel_t ex_alusel_o,
	output id_pkg::aluop_t ex_aluop_o,
	output id_pkg::word_t ex_reg1_o,
	output id_pkg::word_t ex_reg2_o,
	output id_pkg::reg_addr_t ex_waddr_o,
	output logic ex_we_o,
	output id_pkg::word_t ex_link_addr_o,
	output id_pkg::inst_t ex_inst_o,
	output logic ex_in_delayslot_o
);

	id_pkg::br_kind_e br_kind;
	logic link;
	id_pkg::word_t link_addr;

	id_ctrl_if ctrl ();
	operand_if opnd ();

	// register file read port
	assign reg1_re_o = opnd.reg1_re;
	assign reg2_re_o = opnd.reg2_re;
	assign reg1_addr_o = opnd.reg1_addr;
	assign reg2_addr_o = opnd.reg2_addr;
	assign stall_o = opnd.stall;

	inst_decoder u_dec (
		.inst_i(inst_i),
		.ctrl(ctrl.dec),
		.opnd(opnd.dec),
		.br_kind_o(br_kind),
		.link_o(link)
	);

	operand_fwd u_fwd (
		.ex_waddr_i(ex_waddr_i),
		.ex_we_i(ex_we_i),
		.ex_wdata_i(ex_wdata_i),
		.ex_aluop_i(ex_aluop_i),
		.mem_waddr_i(mem_waddr_i),
		.mem_we_i(mem_we_i),
		.mem_wdata_i(mem_wdata_i),
		.reg1_data_i(reg1_data_i),
		.reg2_data_i(reg2_data_i),
		.opnd(opnd.fwd)
	);

	branch_unit u_br (
		.pc_i(pc_i),
		.inst_i(inst_i),
		.br_kind_i(br_kind),
		.link_i(link),
		.opnd(opnd.br),
		.branch_flag_o(branch_flag_o),
		.branch_target_o(branch_target_o),
		.link_addr_o(link_addr)
	);

	id_ex_reg u_pipe (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.stall_i(opnd.stall),
		.branch_flag_i(branch_flag_o),
		.link_addr_i(link_addr),
		.inst_i(inst_i),
		.ctrl(ctrl.pipe),
		.reg1_i(opnd.reg1),
		.reg2_i(opnd.reg2),
		.ex_alusel_o(ex_alusel_o),
		.ex_aluop_o(ex_aluop_o),
		.ex_reg1_o(ex_reg1_o),
		.ex_reg2_o(ex_reg2_o),
		.ex_waddr_o(ex_waddr_o),
		.ex_we_o(ex_we_o),
		.ex_link_addr_o(ex_link_addr_o),
		.ex_inst_o(ex_inst_o),
		.ex_in_delayslot_o(ex_in_delayslot_o)
	);

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input id_pkg::inst_t inst_i,
	id_ctrl_if.dec ctrl,
	operand_if.dec opnd,
	output id_pkg::br_kind_e br_kind_o,
	output logic link_o
);

	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [4:0] sa;
	logic [15:0] imm16;
	logic const_shift;
	logic special_ok;

	assign op = inst_i[31:26];
	assign rs = inst_i[25:21];
	assign rt = inst_i[20:16];
	assign rd = inst_i[15:11];
	assign sa = inst_i[10:6];
	assign fn = inst_i[5:0];
	assign imm16 = inst_i[15:0];

	assign const_shift = (fn == id_pkg::FN_SLL) || (fn == id_pkg::FN_SRL) ||
		(fn == id_pkg::FN_SRA);
	// constant shifts want rs zero, the rest want sa zero
	assign special_ok = const_shift ? (rs == 5'd0) : (sa == 5'd0);

	function automatic id_pkg::aluop_t special_op(input logic [5:0] f);
		case (f)
			id_pkg::FN_SLL, id_pkg::FN_SLLV: special_op = id_pkg::ALUOP_SLL;
			id_pkg::FN_SRL, id_pkg::FN_SRLV: special_op = id_pkg::ALUOP_SRL;
			id_pkg::FN_SRA, id_pkg::FN_SRAV: special_op = id_pkg::ALUOP_SRA;
			id_pkg::FN_AND: special_op = id_pkg::ALUOP_AND;
			id_pkg::FN_OR: special_op = id_pkg::ALUOP_OR;
			id_pkg::FN_XOR: special_op = id_pkg::ALUOP_XOR;
			id_pkg::FN_NOR: special_op = id_pkg::ALUOP_NOR;
			id_pkg::FN_ADD: special_op = id_pkg::ALUOP_ADD;
			id_pkg::FN_ADDU: special_op = id_pkg::ALUOP_ADDU;
			id_pkg::FN_SUB: special_op = id_pkg::ALUOP_SUB;
			id_pkg::FN_SUBU: special_op = id_pkg::ALUOP_SUBU;
			id_pkg::FN_SLT: special_op = id_pkg::ALUOP_SLT;
			id_pkg::FN_SLTU: special_op = id_pkg::ALUOP_SLTU;
			id_pkg::FN_JR: special_op = id_pkg::ALUOP_JR;
			id_pkg::FN_JALR: special_op = id_pkg::ALUOP_JALR;
			default: special_op = id_pkg::ALUOP_NOP;
		endcase
	endfunction

	function automatic id_pkg::aluop_t imm_op(input logic [5:0] o);
		case (o)
			id_pkg::OP_ADDI: imm_op = id_pkg::ALUOP_ADD;
			id_pkg::OP_ADDIU: imm_op = id_pkg::ALUOP_ADDU;
			id_pkg::OP_SLTI: imm_op = id_pkg::ALUOP_SLT;
			id_pkg::OP_SLTIU: imm_op = id_pkg::ALUOP_SLTU;
			id_pkg::OP_ANDI: imm_op = id_pkg::ALUOP_AND;
			id_pkg::OP_XORI: imm_op = id_pkg::ALUOP_XOR;
			default: imm_op = id_pkg::ALUOP_OR;   // ori, lui
		endcase
	endfunction

	always_comb begin
		ctrl.alusel = id_pkg::ALUSEL_NOP;
		ctrl.aluop = id_pkg::ALUOP_NOP;
		ctrl.we = 1'b0;
		ctrl.waddr = rd;
		opnd.reg1_re = 1'b0;
		opnd.reg2_re = 1'b0;
		opnd.reg1_addr = rs;
		opnd.reg2_addr = rt;
		opnd.imm = '0;
		br_kind_o = id_pkg::BR_NONE;
		link_o = 1'b0;
		case (op)
			id_pkg::OP_SPECIAL: begin
				if (special_ok && special_op(fn) != id_pkg::ALUOP_NOP) begin
					ctrl.aluop = special_op(fn);
					ctrl.we = 1'b1;
					opnd.reg1_re = 1'b1;
					opnd.reg2_re = 1'b1;
					case (fn)
						id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA: begin
							ctrl.alusel = id_pkg::ALUSEL_SHIFT;
							opnd.reg1_re = 1'b0;   // sa goes out as reg1
							opnd.imm = {27'd0, sa};
						end
						id_pkg::FN_SLLV, id_pkg::FN_SRLV, id_pkg::FN_SRAV:
							ctrl.alusel = id_pkg::ALUSEL_SHIFT;
						id_pkg::FN_AND, id_pkg::FN_OR, id_pkg::FN_XOR, id_pkg::FN_NOR:
							ctrl.alusel = id_pkg::ALUSEL_LOGIC;
						id_pkg::FN_JR, id_pkg::FN_JALR: begin
							ctrl.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
							ctrl.we = (fn == id_pkg::FN_JALR);   // jalr links to rd
							link_o = (fn == id_pkg::FN_JALR);
							opnd.reg2_re = 1'b0;
							br_kind_o = id_pkg::BR_JR;
						end
						default: ctrl.alusel = id_pkg::ALUSEL_MATH;
					endcase
				end
			end
			id_pkg::OP_ADDI, id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU,
			id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI, id_pkg::OP_LUI: begin
				// op[2] splits the math group from the logic group
				ctrl.alusel = op[2] ? id_pkg::ALUSEL_LOGIC : id_pkg::ALUSEL_MATH;
				ctrl.aluop = imm_op(op);
				ctrl.we = 1'b1;
				ctrl.waddr = rt;
				opnd.reg1_re = 1'b1;   // lui too, reads rs
				case (op)
					id_pkg::OP_LUI: opnd.imm = {imm16, 16'h0000};
					id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI:
						opnd.imm = {16'h0000, imm16};
					default: opnd.imm = {{16{imm16[15]}}, imm16};
				endcase
			end
			id_pkg::OP_J, id_pkg::OP_JAL: begin
				ctrl.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
				ctrl.aluop = (op == id_pkg::OP_JAL) ? id_pkg::ALUOP_JAL : id_pkg::ALUOP_J;
				ctrl.we = (op == id_pkg::OP_JAL);
				ctrl.waddr = id_pkg::RA_ADDR;
				link_o = (op == id_pkg::OP_JAL);
				br_kind_o = id_pkg::BR_J;
			end
			id_pkg::OP_BEQ, id_pkg::OP_BNE: begin
				ctrl.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
				ctrl.aluop = (op == id_pkg::OP_BEQ) ? id_pkg::ALUOP_BEQ : id_pkg::ALUOP_BNE;
				opnd.reg1_re = 1'b1;
				opnd.reg2_re = 1'b1;
				br_kind_o = (op == id_pkg::OP_BEQ) ? id_pkg::BR_EQ : id_pkg::BR_NE;
			end
			id_pkg::OP_BLEZ, id_pkg::OP_BGTZ: begin
				ctrl.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
				ctrl.aluop = (op == id_pkg::OP_BLEZ) ? id_pkg::ALUOP_BLEZ : id_pkg::ALUOP_BGTZ;
				opnd.reg1_re = 1'b1;
				br_kind_o = (op == id_pkg::OP_BLEZ) ? id_pkg::BR_LEZ : id_pkg::BR_GTZ;
			end
			id_pkg::OP_REGIMM: begin
				case (rt)
					id_pkg::RT_BLTZ, id_pkg::RT_BLTZAL: begin
						ctrl.aluop = rt[4] ? id_pkg::ALUOP_BLTZAL : id_pkg::ALUOP_BLTZ;
						br_kind_o = id_pkg::BR_LTZ;
					end
					id_pkg::RT_BGEZ, id_pkg::RT_BGEZAL: begin
						ctrl.aluop = rt[4] ? id_pkg::ALUOP_BGEZAL : id_pkg::ALUOP_BGEZ;
						br_kind_o = id_pkg::BR_GEZ;
					end
					default: begin
					end
				endcase
				if (br_kind_o != id_pkg::BR_NONE) begin
					ctrl.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
					ctrl.we = rt[4];   // al forms write ra
					ctrl.waddr = id_pkg::RA_ADDR;
					link_o = rt[4];
					opnd.reg1_re = 1'b1;
				end
			end
			id_pkg::OP_LW: begin
				ctrl.alusel = id_pkg::ALUSEL_LOAD_STORE;
				ctrl.aluop = id_pkg::ALUOP_LW;
				ctrl.we = 1'b1;
				ctrl.waddr = rt;
				opnd.reg1_re = 1'b1;
			end
			id_pkg::OP_SW: begin
				ctrl.alusel = id_pkg::ALUSEL_LOAD_STORE;
				ctrl.aluop = id_pkg::ALUOP_SW;
				opnd.reg1_re = 1'b1;
				opnd.reg2_re = 1'b1;
			end
			default: begin   // anything else passes as nop
			end
		endcase
	end

endmodule

//--- logic/operand_fwd.sv
`timescale 1ns/1ps

module operand_fwd (
	input id_pkg::reg_addr_t ex_waddr_i,
	input logic ex_we_i,
	input id_pkg::word_t ex_wdata_i,
	input id_pkg::aluop_t ex_aluop_i,
	input id_pkg::reg_addr_t mem_waddr_i,
	input logic mem_we_i,
	input id_pkg::word_t mem_wdata_i,
	input id_pkg::word_t reg1_data_i,
	input id_pkg::word_t reg2_data_i,
	operand_if.fwd opnd
);

	logic ex_is_load;
	logic load_use1;
	logic load_use2;

	// newest write wins, register 0 included
	function automatic id_pkg::word_t pick(input logic re, input id_pkg::reg_addr_t addr,
			input id_pkg::word_t rf_data);
		if (!re)
			pick = opnd.imm;
		else if (ex_we_i && ex_waddr_i == addr)
			pick = ex_wdata_i;
		else if (mem_we_i && mem_waddr_i == addr)
			pick = mem_wdata_i;
		else
			pick = rf_data;
	endfunction

	assign ex_is_load = (ex_aluop_i == id_pkg::ALUOP_LW);   // lw data not ready until MEM

	assign load_use1 = opnd.reg1_re && ex_is_load && (ex_waddr_i == opnd.reg1_addr);
	assign load_use2 = opnd.reg2_re && ex_is_load && (ex_waddr_i == opnd.reg2_addr);
	assign opnd.stall = load_use1 | load_use2;

	always_comb begin
		opnd.reg1 = pick(opnd.reg1_re, opnd.reg1_addr, reg1_data_i);
		opnd.reg2 = pick(opnd.reg2_re, opnd.reg2_addr, reg2_data_i);
	end

endmodule

//--- tests/id_stage_props.sv
`timescale 1ns/1ps

module id_stage_props (
	input logic clk,
	input logic rst_n_i,
	input id_pkg::aluop_t ex_aluop_i,
	input logic stall_o,
	input logic branch_flag_o,
	input logic ex_we_o,
	input id_pkg::aluop_t ex_aluop_o,
	input id_pkg::alusel_t ex_alusel_o,
	input logic ex_in_delayslot_o
);

	int fail_count = 0;

	// only lw in EX counts as a load
	stall_needs_load: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_o |-> ex_aluop_i == id_pkg::ALUOP_LW)
		else begin
			fail_count++;
			$error("stall_o high without lw in EX");
		end

	no_branch_in_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_o |-> !branch_flag_o)
		else begin
			fail_count++;
			$error("branch_flag_o high during a stall");
		end

	// stalled edge loads a bubble
	bubble_after_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_o |=> !ex_we_o && ex_aluop_o == id_pkg::ALUOP_NOP &&
			ex_alusel_o == id_pkg::ALUSEL_NOP)
		else begin
			fail_count++;
			$error("no bubble after a stalled edge");
		end

	delay_slot_set: assert property (@(posedge clk) disable iff (!rst_n_i)
		branch_flag_o ##1 !stall_o |=> ex_in_delayslot_o)
		else begin
			fail_count++;
			$error("delay slot flag missing after a taken branch");
		end

	delay_slot_clear: assert property (@(posedge clk) disable iff (!rst_n_i)
		!branch_flag_o && !stall_o ##1 !stall_o |=> !ex_in_delayslot_o)
		else begin
			fail_count++;
			$error("delay slot flag set without a taken branch");
		end

	reset_quiet: assert property (@(posedge clk)
		!rst_n_i |=> !ex_we_o && !ex_in_delayslot_o && ex_aluop_o == id_pkg::ALUOP_NOP)
		else begin
			fail_count++;
			$error("ID/EX register not cleared by reset");
		end

endmodule

//--- tests/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;

	logic clk;
	logic rst_n_i;
	id_pkg::word_t pc_i;
	id_pkg::inst_t inst_i;
	id_pkg::word_t reg1_data_i;
	id_pkg::word_t reg2_data_i;
	id_pkg::reg_addr_t ex_waddr_i;
	logic ex_we_i;
	id_pkg::word_t ex_wdata_i;
	id_pkg::aluop_t ex_aluop_i;
	id_pkg::reg_addr_t mem_waddr_i;
	logic mem_we_i;
	id_pkg::word_t mem_wdata_i;
	logic reg1_re_o;
	logic reg2_re_o;
	id_pkg::reg_addr_t reg1_addr_o;
	id_pkg::reg_addr_t reg2_addr_o;
	logic branch_flag_o;
	id_pkg::word_t branch_target_o;
	logic stall_o;
	id_pkg::alusel_t ex_alusel_o;
	id_pkg::aluop_t ex_aluop_o;
	id_pkg::word_t ex_reg1_o;
	id_pkg::word_t ex_reg2_o;
	id_pkg::reg_addr_t ex_waddr_o;
	logic ex_we_o;
	id_pkg::word_t ex_link_addr_o;
	id_pkg::inst_t ex_inst_o;
	logic ex_in_delayslot_o;

	// EX/MEM values applied at the next step
	logic nx_ex_we;
	id_pkg::reg_addr_t nx_ex_waddr;
	id_pkg::word_t nx_ex_wdata;
	id_pkg::aluop_t nx_ex_aluop;
	logic nx_mem_we;
	id_pkg::reg_addr_t nx_mem_waddr;
	id_pkg::word_t nx_mem_wdata;

	int errors = 0;
	logic [31:0] lfsr = 32'h7d81_8d08;

	id_stage dut0 (.*);

	bind id_stage id_stage_props props0 (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic id_pkg::word_t rf_value(input id_pkg::reg_addr_t a);
		return (a == 5'd0) ? 32'd0 : {27'd0, a} * 32'h0101_0101;
	endfunction

	assign reg1_data_i = rf_value(reg1_addr_o);
	assign reg2_data_i = rf_value(reg2_addr_o);

	// taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		int b;
		v = '0;
		for (b = 0; b < n; b++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// r-type flag, opcode or funct, aluop, alusel, operand form
	// form 0 sa shift, 1 two regs, 2 sign ext, 3 zero ext, 4 upper half
	function automatic logic [20:0] alu_entry(input int k);
		case (k)
			0: return {1'b1, id_pkg::FN_SLL, id_pkg::ALUOP_SLL, id_pkg::ALUSEL_SHIFT, 3'd0};
			1: return {1'b1, id_pkg::FN_SRL, id_pkg::ALUOP_SRL, id_pkg::ALUSEL_SHIFT, 3'd0};
			2: return {1'b1, id_pkg::FN_SRA, id_pkg::ALUOP_SRA, id_pkg::ALUSEL_SHIFT, 3'd0};
			3: return {1'b1, id_pkg::FN_SLLV, id_pkg::ALUOP_SLL, id_pkg::ALUSEL_SHIFT, 3'd1};
			4: return {1'b1, id_pkg::FN_SRLV, id_pkg::ALUOP_SRL, id_pkg::ALUSEL_SHIFT, 3'd1};
			5: return {1'b1, id_pkg::FN_SRAV, id_pkg::ALUOP_SRA, id_pkg::ALUSEL_SHIFT, 3'd1};
			6: return {1'b1, id_pkg::FN_AND, id_pkg::ALUOP_AND, id_pkg::ALUSEL_LOGIC, 3'd1};
			7: return {1'b1, id_pkg::FN_OR, id_pkg::ALUOP_OR, id_pkg::ALUSEL_LOGIC, 3'd1};
			8: return {1'b1, id_pkg::FN_XOR, id_pkg::ALUOP_XOR, id_pkg::ALUSEL_LOGIC, 3'd1};
			9: return {1'b1, id_pkg::FN_NOR, id_pkg::ALUOP_NOR, id_pkg::ALUSEL_LOGIC, 3'd1};
			10: return {1'b1, id_pkg::FN_ADD, id_pkg::ALUOP_ADD, id_pkg::ALUSEL_MATH, 3'd1};
			11: return {1'b1, id_pkg::FN_ADDU, id_pkg::ALUOP_ADDU, id_pkg::ALUSEL_MATH, 3'd1};
			12: return {1'b1, id_pkg::FN_SUB, id_pkg::ALUOP_SUB, id_pkg::ALUSEL_MATH, 3'd1};
			13: return {1'b1, id_pkg::FN_SUBU, id_pkg::ALUOP_SUBU, id_pkg::ALUSEL_MATH, 3'd1};
			14: return {1'b1, id_pkg::FN_SLT, id_pkg::ALUOP_SLT, id_pkg::ALUSEL_MATH, 3'd1};
			15: return {1'b1, id_pkg::FN_SLTU, id_pkg::ALUOP_SLTU, id_pkg::ALUSEL_MATH, 3'd1};
			16: return {1'b0, id_pkg::OP_ADDI, id_pkg::ALUOP_ADD, id_pkg::ALUSEL_MATH, 3'd2};
			17: return {1'b0, id_pkg::OP_ADDIU, id_pkg::ALUOP_ADDU, id_pkg::ALUSEL_MATH, 3'd2};
			18: return {1'b0, id_pkg::OP_SLTI, id_pkg::ALUOP_SLT, id_pkg::ALUSEL_MATH, 3'd2};
			19: return {1'b0, id_pkg::OP_SLTIU, id_pkg::ALUOP_SLTU, id_pkg::ALUSEL_MATH, 3'd2};
			20: return {1'b0, id_pkg::OP_ANDI, id_pkg::ALUOP_AND, id_pkg::ALUSEL_LOGIC, 3'd3};
			21: return {1'b0, id_pkg::OP_ORI, id_pkg::ALUOP_OR, id_pkg::ALUSEL_LOGIC, 3'd3};
			22: return {1'b0, id_pkg::OP_XORI, id_pkg::ALUOP_XOR, id_pkg::ALUSEL_LOGIC, 3'd3};
			default: return {1'b0, id_pkg::OP_LUI, id_pkg::ALUOP_OR, id_pkg::ALUSEL_LOGIC, 3'd4};
		endcase
	endfunction

	// inst, taken, target form (0 index, 1 register, 2 offset), link register
	// r9 holds a negative value through MEM forwarding
	function automatic logic [39:0] br_entry(input int k);
		case (k)
			0: return {id_pkg::OP_J, 26'h012_3456, 1'b1, 2'd0, 5'd0};
			1: return {id_pkg::OP_JAL, 26'h2ab_cdef, 1'b1, 2'd0, id_pkg::RA_ADDR};
			2: return {id_pkg::OP_SPECIAL, 5'd3, 15'd0, id_pkg::FN_JR, 1'b1, 2'd1, 5'd0};
			3: return {id_pkg::OP_SPECIAL, 5'd3, 5'd0, 5'd7, 5'd0, id_pkg::FN_JALR, 1'b1, 2'd1, 5'd7};
			4: return {id_pkg::OP_BEQ, 5'd3, 5'd3, 16'h0010, 1'b1, 2'd2, 5'd0};
			5: return {id_pkg::OP_BEQ, 5'd3, 5'd4, 16'h0010, 1'b0, 2'd2, 5'd0};
			6: return {id_pkg::OP_BNE, 5'd3, 5'd4, 16'hfff0, 1'b1, 2'd2, 5'd0};
			7: return {id_pkg::OP_BNE, 5'd3, 5'd3, 16'hfff0, 1'b0, 2'd2, 5'd0};
			8: return {id_pkg::OP_BLEZ, 5'd0, 5'd0, 16'h0020, 1'b1, 2'd2, 5'd0};
			9: return {id_pkg::OP_BLEZ, 5'd9, 5'd0, 16'h8000, 1'b1, 2'd2, 5'd0};
			10: return {id_pkg::OP_BLEZ, 5'd3, 5'd0, 16'h0020, 1'b0, 2'd2, 5'd0};
			11: return {id_pkg::OP_BGTZ, 5'd3, 5'd0, 16'h7fff, 1'b1, 2'd2, 5'd0};
			12: return {id_pkg::OP_BGTZ, 5'd0, 5'd0, 16'h0004, 1'b0, 2'd2, 5'd0};
			13: return {id_pkg::OP_BGTZ, 5'd9, 5'd0, 16'h0004, 1'b0, 2'd2, 5'd0};
			14: return {id_pkg::OP_REGIMM, 5'd9, id_pkg::RT_BLTZ, 16'hff00, 1'b1, 2'd2, 5'd0};
			15: return {id_pkg::OP_REGIMM, 5'd0, id_pkg::RT_BLTZ, 16'hff00, 1'b0, 2'd2, 5'd0};
			16: return {id_pkg::OP_REGIMM, 5'd0, id_pkg::RT_BGEZ, 16'h0100, 1'b1, 2'd2, 5'd0};
			17: return {id_pkg::OP_REGIMM, 5'd9, id_pkg::RT_BGEZ, 16'h0100, 1'b0, 2'd2, 5'd0};
			18: return {id_pkg::OP_REGIMM, 5'd9, id_pkg::RT_BLTZAL, 16'h0040, 1'b1, 2'd2,
				id_pkg::RA_ADDR};
			19: return {id_pkg::OP_REGIMM, 5'd3, id_pkg::RT_BLTZAL, 16'h0040, 1'b0, 2'd2,
				id_pkg::RA_ADDR};
			20: return {id_pkg::OP_REGIMM, 5'd3, id_pkg::RT_BGEZAL, 16'hffc0, 1'b1, 2'd2,
				id_pkg::RA_ADDR};
			default: return {id_pkg::OP_REGIMM, 5'd9, id_pkg::RT_BGEZAL, 16'hffc0, 1'b0, 2'd2,
				id_pkg::RA_ADDR};
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("** Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bubble();
		check("ex_we_o", ex_we_o, 1'b0);
		check("ex_aluop_o", ex_aluop_o, id_pkg::ALUOP_NOP);
		check("ex_alusel_o", ex_alusel_o, id_pkg::ALUSEL_NOP);
		check("ex_reg1_o", ex_reg1_o, '0);
		check("ex_reg2_o", ex_reg2_o, '0);
		check("ex_waddr_o", ex_waddr_o, '0);
	endtask

	// present one instruction, then settle to the falling edge
	task automatic step(input id_pkg::inst_t inst, input id_pkg::word_t pc);
		@(posedge clk);
		inst_i <= inst;
		pc_i <= pc;
		ex_we_i <= nx_ex_we;
		ex_waddr_i <= nx_ex_waddr;
		ex_wdata_i <= nx_ex_wdata;
		ex_aluop_i <= nx_ex_aluop;
		mem_we_i <= nx_mem_we;
		mem_waddr_i <= nx_mem_waddr;
		mem_wdata_i <= nx_mem_wdata;
		@(negedge clk);
	endtask

	task automatic wait_stall_clear();
		int n;
		n = 0;
		while (stall_o && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (stall_o) begin
			errors++;
			$display("timeout: stall_o still high after %0d cycles", n);
		end
	endtask

	task automatic fwd_case(input logic ewe, input id_pkg::reg_addr_t ewa, input logic mwe,
			input id_pkg::reg_addr_t mwa, input id_pkg::word_t exp1, input id_pkg::word_t exp2);
		nx_ex_we = ewe;
		nx_ex_waddr = ewa;
		nx_ex_wdata = 32'haaaa_0001;
		nx_ex_aluop = id_pkg::ALUOP_ADD;
		nx_mem_we = mwe;
		nx_mem_waddr = mwa;
		nx_mem_wdata = 32'hbbbb_0002;
		step({id_pkg::OP_SPECIAL, 5'd5, 5'd6, 5'd8, 5'd0, id_pkg::FN_ADD}, 32'h0000_2000);
		step(32'h0, 32'h0000_2004);
		check("ex_reg1_o", ex_reg1_o, exp1);
		check("ex_reg2_o", ex_reg2_o, exp2);
	endtask

	initial begin
		id_pkg::inst_t inst;
		id_pkg::word_t pc;
		id_pkg::word_t exp;
		logic [20:0] ent;
		logic [39:0] bent;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		logic [15:0] imm;
		int i;
		int k;
		rst_n_i = 1'b0;
		pc_i = '0;
		inst_i = '0;
		ex_waddr_i = '0;
		ex_we_i = 1'b0;
		ex_wdata_i = '0;
		ex_aluop_i = id_pkg::ALUOP_NOP;
		mem_waddr_i = '0;
		mem_we_i = 1'b0;
		mem_wdata_i = '0;
		nx_ex_we = 1'b0;
		nx_ex_waddr = '0;
		nx_ex_wdata = '0;
		nx_ex_aluop = id_pkg::ALUOP_NOP;
		nx_mem_we = 1'b0;
		nx_mem_waddr = '0;
		nx_mem_wdata = '0;

		repeat (2) begin
			@(negedge clk);
			check_bubble();
			check("ex_in_delayslot_o", ex_in_delayslot_o, 1'b0);
		end
		@(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);
		check_bubble();
		check("ex_in_delayslot_o", ex_in_delayslot_o, 1'b0);

		// random ALU and immediate ops, nothing in EX/MEM
		pc = 32'h0040_0000;
		for (i = 0; i < 48; i++) begin
			ent = alu_entry(rand_bits(5) % 24);
			rs = 5'(rand_bits(5));
			rt = 5'(rand_bits(5));
			rd = 5'(rand_bits(5));
			sa = 5'(rand_bits(5));
			imm = 16'(rand_bits(16));
			if (ent[20])
				inst = {id_pkg::OP_SPECIAL, (ent[2:0] == 3'd0) ? 5'd0 : rs, rt, rd,
					(ent[2:0] == 3'd0) ? sa : 5'd0, ent[19:14]};
			else
				inst = {ent[19:14], rs, rt, imm};
			step(inst, pc);
			// sa shifts skip rs, immediates skip rt, lui still reads rs
			check("reg1_re_o", reg1_re_o, ent[2:0] != 3'd0);
			check("reg2_re_o", reg2_re_o, ent[2:0] <= 3'd1);
			step(32'h0, pc + 32'd4);
			pc = pc + 32'd8;
			check("ex_aluop_o", ex_aluop_o, ent[13:6]);
			check("ex_alusel_o", ex_alusel_o, ent[5:3]);
			check("ex_we_o", ex_we_o, 1'b1);
			check("ex_waddr_o", ex_waddr_o, ent[20] ? rd : rt);
			check("ex_inst_o", ex_inst_o, inst);
			check("ex_reg1_o", ex_reg1_o, (ent[2:0] == 3'd0) ? {27'd0, sa} : rf_value(rs));
			case (ent[2:0])
				3'd2: exp = {{16{imm[15]}}, imm};
				3'd3: exp = {16'h0000, imm};
				3'd4: exp = {imm, 16'h0000};
				default: exp = rf_value(rt);
			endcase
			check("ex_reg2_o", ex_reg2_o, exp);
		end

		// EX over MEM over register file
		fwd_case(1'b1, 5'd5, 1'b1, 5'd5, 32'haaaa_0001, 32'h0606_0606);
		fwd_case(1'b1, 5'd7, 1'b1, 5'd5, 32'hbbbb_0002, 32'h0606_0606);
		fwd_case(1'b1, 5'd6, 1'b1, 5'd5, 32'hbbbb_0002, 32'haaaa_0001);
		fwd_case(1'b0, 5'd5, 1'b0, 5'd6, 32'h0505_0505, 32'h0606_0606);

		nx_ex_we = 1'b0;
		nx_ex_aluop = id_pkg::ALUOP_NOP;
		nx_mem_we = 1'b1;
		nx_mem_waddr = 5'd9;
		nx_mem_wdata = 32'h8000_0010;
		pc = 32'hbfc0_0100;
		for (k = 0; k < 22; k++) begin
			bent = br_entry(k);
			inst = bent[39:8];
			step(inst, pc);
			check("branch_flag_o", branch_flag_o, bent[7]);
			case (bent[6:5])
				2'd0: begin
					exp = pc + 32'd4;
					exp = {exp[31:28], inst[25:0], 2'b00};
				end
				2'd1: exp = rf_value(inst[25:21]);
				default: exp = pc + 32'd4 + {{14{inst[15]}}, inst[15:0], 2'b00};
			endcase
			check("branch_target_o", branch_target_o, exp);
			step(32'h0, pc + 32'd4);
			check("ex_we_o", ex_we_o, bent[4:0] != 5'd0);
			if (bent[4:0] != 5'd0) begin
				check("ex_waddr_o", ex_waddr_o, bent[4:0]);
				check("ex_link_addr_o", ex_link_addr_o, pc + 32'd8);
			end else begin
				check("ex_link_addr_o", ex_link_addr_o, '0);
			end
			step(32'h0, pc + 32'd8);
			check("ex_in_delayslot_o", ex_in_delayslot_o, bent[7]);
			pc = pc + 32'h100;
		end
		nx_mem_we = 1'b0;

		// lw to r5 sits in EX
		nx_ex_we = 1'b1;
		nx_ex_waddr = 5'd5;
		nx_ex_wdata = 32'h1234_5678;
		nx_ex_aluop = id_pkg::ALUOP_LW;
		step({id_pkg::OP_BEQ, 5'd5, 5'd5, 16'h0004}, 32'h0000_3000);
		check("stall_o", stall_o, 1'b1);
		check("branch_flag_o", branch_flag_o, 1'b0);
		step({6'h3f, 5'd5, 5'd5, 16'h0000}, 32'h0000_3004);   // unknown op, no reads
		check_bubble();
		check("stall_o", stall_o, 1'b0);
		step({id_pkg::OP_SW, 5'd1, 5'd5, 16'h0008}, 32'h0000_3008);
		check_bubble();
		check("stall_o", stall_o, 1'b1);

		// taken branch, then a stalled delay slot
		nx_ex_we = 1'b0;
		nx_ex_aluop = id_pkg::ALUOP_ADD;
		step({id_pkg::OP_BEQ, 5'd3, 5'd3, 16'h0008}, 32'h0000_4000);
		check("branch_flag_o", branch_flag_o, 1'b1);
		nx_ex_we = 1'b1;
		nx_ex_aluop = id_pkg::ALUOP_LW;
		inst = {id_pkg::OP_SPECIAL, 5'd5, 5'd6, 5'd8, 5'd0, id_pkg::FN_ADD};
		step(inst, 32'h0000_4004);
		check("stall_o", stall_o, 1'b1);
		nx_ex_aluop = id_pkg::ALUOP_ADD;
		step(inst, 32'h0000_4004);
		check_bubble();
		check("ex_in_delayslot_o", ex_in_delayslot_o, 1'b0);
		wait_stall_clear();
		step(32'h0, 32'h0000_4008);
		check("ex_in_delayslot_o", ex_in_delayslot_o, 1'b1);
		check("ex_aluop_o", ex_aluop_o, id_pkg::ALUOP_ADD);
		check("ex_reg1_o", ex_reg1_o, 32'h1234_5678);
		step(32'h0, 32'h0000_400c);

		$display("errors: %0d immediate, %0d concurrent", errors, dut0.props0.fail_count);
		if (errors == 0 && dut0.props0.fail_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
